/* list.f */
verilog/rob_pkg.sv
verilog/rob_ifs.sv
verilog/rob_dispatch_queue.sv
verilog/rob_result_file.sv
verilog/rob_commit.sv
verilog/rob_top.sv
testbench/rob_tb.sv

/* testbench/rob_tb.sv */
`timescale 1ns/100ps

module rob_tb;
    import rob_pkg::*;

    localparam int DEPTH = 8;
    localparam int N_INSTR = 200;
    localparam int CLK_PERIOD = 100;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_ALU    = 7'b0110011;
    localparam logic [6:0] OPC_ALUI   = 7'b0010011;

    // expected commit outputs of one cycle
    typedef struct packed {
        logic     reg_wr;
        reg_idx_t idx;
        rob_tag_t tag;
        data_t    value;
        rob_tag_t store_tag;
        logic     br;
        data_t    pc;
        logic     taken;
        logic     mis;
        data_t    redirect;
    } commit_t;

    logic     clk, rst, ena, alloc_valid, alloc_pred_taken, full, cdb_is_jump;
    data_t    alloc_inst, alloc_pc, cdb_value, cdb_jump_addr, ls_value;
    data_t    query_value1, query_value2, reg_wr_value, br_pc, redirect_pc;
    reg_idx_t alloc_dest, reg_wr_idx;
    rob_tag_t alloc_tag, cdb_tag, ls_tag, query_tag1, query_tag2, reg_wr_tag, store_commit_tag;
    logic     query_ready1, query_ready2, reg_wr_valid, br_valid, br_taken, misbranch;

    // model, indexed by tag, with tags in program order
    data_t    e_inst [0:15];
    data_t    e_pc [0:15];
    data_t    e_value [0:15];
    data_t    e_addr [0:15];
    reg_idx_t e_dest [0:15];
    logic     e_pred [0:15];
    logic     e_jump [0:15];
    bit       e_written [0:15];
    int       e_alloc_edge [0:15];
    int       e_wb_edge [0:15];
    rob_tag_t order_q [$];
    rob_tag_t next_tag;
    data_t    pc;
    integer   seed;
    int       cyc = 0;
    int       n_alloc = 0;
    int       n_checks = 0;
    int       errors = 0;
    logic     ena_seen = 1'b0;

    rob_top #(.ROB_DEPTH(DEPTH)) DUT (
        .clk, .rst, .ena,
        .alloc_valid, .alloc_inst, .alloc_dest, .alloc_pc, .alloc_pred_taken,
        .alloc_tag, .full,
        .cdb_tag, .cdb_value, .cdb_jump_addr, .cdb_is_jump, .ls_tag, .ls_value,
        .query_tag1, .query_tag2, .query_value1, .query_value2,
        .query_ready1, .query_ready2,
        .reg_wr_valid, .reg_wr_idx, .reg_wr_tag, .reg_wr_value, .store_commit_tag,
        .br_valid, .br_pc, .br_taken, .misbranch, .redirect_pc
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc      <= cyc + 1;
        ena_seen <= ena;
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic bit is_mem(input rob_tag_t t);
        return (e_inst[t][6:0] == OPC_LOAD) || (e_inst[t][6:0] == OPC_STORE);
    endfunction

    // commit rules of the four instruction kinds
    function automatic commit_t expected_commit(input rob_tag_t t);
        commit_t c;
        c = '0;
        case (e_inst[t][6:0])
            OPC_STORE: c.store_tag = t;
            OPC_BRANCH: begin
                c.br    = 1'b1;
                c.taken = e_jump[t];
                c.mis   = e_jump[t] != e_pred[t];
            end
            OPC_JALR: begin
                c.br     = 1'b1;
                c.taken  = 1'b1;
                c.mis    = 1'b1;
                c.reg_wr = e_dest[t] != 5'd0;
            end
            default: c.reg_wr = e_dest[t] != 5'd0;
        endcase
        c.idx      = e_dest[t];
        c.tag      = t;
        c.value    = e_value[t];
        c.pc       = e_pc[t];
        c.redirect = e_addr[t];
        return c;
    endfunction

    function automatic data_t random_inst();
        data_t w;
        w = $random(seed);
        case ({$random(seed)} % 6)
            0: w[6:0] = OPC_LOAD;
            1: w[6:0] = OPC_STORE;
            2: w[6:0] = OPC_BRANCH;
            3: w[6:0] = OPC_JALR;
            4: w[6:0] = OPC_ALU;
            default: w[6:0] = OPC_ALUI;
        endcase
        return w;
    endfunction

    // an allocated entry still waiting for its result
    function automatic rob_tag_t pick_pending(input bit mem);
        int start;
        int k;
        rob_tag_t t;
        if (order_q.size() == 0) return '0;
        start = {$random(seed)} % order_q.size();
        for (k = 0; k < order_q.size(); k++) begin
            t = order_q[(start + k) % order_q.size()];
            if (!e_written[t] && e_alloc_edge[t] <= cyc && is_mem(t) == mem) return t;
        end
        return '0;
    endfunction

    // with ena low the bus is driven but the model keeps the entry pending
    task automatic write_back(input rob_tag_t t, input bit en);
        data_t v;
        data_t a;
        logic  j;
        v = $random(seed);
        a = $random(seed) & ~32'h3;
        j = (e_inst[t][6:0] == OPC_JALR) ||
            (e_inst[t][6:0] == OPC_BRANCH && ({$random(seed)} % 2) == 1);
        if (is_mem(t)) begin
            ls_tag   = t;
            ls_value = v;
        end else begin
            cdb_tag       = t;
            cdb_value     = v;
            cdb_jump_addr = a;
            cdb_is_jump   = j;
        end
        if (en) begin
            e_written[t] = 1'b1;
            e_wb_edge[t] = cyc + 1;
            e_value[t]   = v;
            e_jump[t]    = j;
            e_addr[t]    = a;
        end
    endtask

    task automatic try_alloc(input bit en);
        rob_tag_t t;
        compare("alloc_tag", alloc_tag, next_tag);
        if (order_q.size() >= DEPTH || n_alloc >= N_INSTR) return;
        alloc_valid      = 1'b1;
        alloc_inst       = random_inst();
        alloc_dest       = $random(seed);
        alloc_pc         = pc;
        alloc_pred_taken = $random(seed);
        if (!en) return;
        t = next_tag;
        e_inst[t]       = alloc_inst;
        e_dest[t]       = alloc_dest;
        e_pc[t]         = alloc_pc;
        e_pred[t]       = alloc_pred_taken;
        e_written[t]    = 1'b0;
        e_alloc_edge[t] = cyc + 1;
        order_q.push_back(t);
        next_tag = (t == rob_tag_t'(DEPTH)) ? rob_tag_t'(1) : t + rob_tag_t'(1);
        pc += 4;
        n_alloc++;
    endtask

    // an entry can only have retired once nothing older is still waiting
    task automatic check_query(input rob_tag_t t, input logic rdy, input data_t val);
        int  k;
        int  pos;
        bit  blocked;
        if (t == '0) begin
            compare("query ready of tag 0", rdy, 1'b0);
            compare("query value of tag 0", val, '0);
            return;
        end
        pos = -1;
        blocked = 1'b0;
        for (k = 0; k < order_q.size(); k++) begin
            if (order_q[k] == t) begin
                pos = k;
                break;
            end
            if (!(e_written[order_q[k]] && e_wb_edge[order_q[k]] <= cyc)) blocked = 1'b1;
        end
        if (pos < 0 || e_alloc_edge[t] > cyc) return;
        if (!(e_written[t] && e_wb_edge[t] <= cyc)) begin
            compare("query ready of pending entry", rdy, 1'b0);
        end else if (blocked) begin
            compare("query ready of written entry", rdy, 1'b1);
            compare("query value", val, e_value[t]);
        end
    endtask

    function automatic rob_tag_t pick_query();
        if (order_q.size() == 0 || ({$random(seed)} % 8) == 0) return '0;
        return order_q[{$random(seed)} % order_q.size()];
    endfunction

    task automatic drive_cycle(input bit do_wb, input bit do_alloc, input bit en);
        rob_tag_t t;
        @(posedge clk);
        #10;
        check_query(query_tag1, query_ready1, query_value1);
        check_query(query_tag2, query_ready2, query_value2);
        ena         = en;
        alloc_valid = 1'b0;
        cdb_tag     = '0;
        ls_tag      = '0;
        if (do_wb && ({$random(seed)} % 4) != 0) begin
            t = pick_pending(1'b0);
            if (t != '0) write_back(t, en);
        end
        if (do_wb && ({$random(seed)} % 4) != 0) begin
            t = pick_pending(1'b1);
            if (t != '0) write_back(t, en);
        end
        if (do_alloc) try_alloc(en);
        query_tag1 = pick_query();
        query_tag2 = pick_query();
    endtask

    // commit pulses against the head of the model, every cycle
    always @(negedge clk) begin : commit_check
        commit_t  exp;
        rob_tag_t h;
        if (!rst) begin
            exp = '0;
            if (order_q.size() > 0) begin
                h = order_q[0];
                if (ena_seen && e_alloc_edge[h] < cyc && e_written[h] && e_wb_edge[h] < cyc) begin
                    exp = expected_commit(h);
                    void'(order_q.pop_front());
                end
            end
            compare("reg_wr_valid", reg_wr_valid, exp.reg_wr);
            compare("store_commit_tag", store_commit_tag, exp.store_tag);
            compare("br_valid", br_valid, exp.br);
            compare("misbranch", misbranch, exp.mis);
            if (exp.reg_wr) begin
                compare("reg_wr_idx", reg_wr_idx, exp.idx);
                compare("reg_wr_tag", reg_wr_tag, exp.tag);
                compare("reg_wr_value", reg_wr_value, exp.value);
            end
            if (exp.br) begin
                compare("br_pc", br_pc, exp.pc);
                compare("br_taken", br_taken, exp.taken);
                compare("redirect_pc", redirect_pc, exp.redirect);
            end
        end
    end

    initial begin
        #(CLK_PERIOD * 4 * N_INSTR * DEPTH);
        $display("timeout: the ROB did not retire all %0d instructions in time", N_INSTR);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        seed = 32'hc4b1_a8c0;
        rst = 1'b1;
        ena = 1'b1;
        alloc_valid = 1'b0;
        alloc_inst = '0;
        alloc_dest = '0;
        alloc_pc = '0;
        alloc_pred_taken = 1'b0;
        cdb_tag = '0;
        cdb_value = '0;
        cdb_jump_addr = '0;
        cdb_is_jump = 1'b0;
        ls_tag = '0;
        ls_value = '0;
        query_tag1 = '0;
        query_tag2 = '0;
        next_tag = rob_tag_t'(1);
        pc = 32'h0000_1000;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        @(posedge clk);
        #10;
        compare("full after reset", full, 1'b0);
        compare("alloc_tag after reset", alloc_tag, 4'd1);
        // fill with no write-backs, then push against a full ROB
        repeat (DEPTH) drive_cycle(1'b0, 1'b1, 1'b1);
        repeat (2) begin
            @(posedge clk);
            #10;
            compare("full when filled", full, 1'b1);
            compare("alloc_tag while full", alloc_tag, next_tag);
            alloc_valid = 1'b1;
            alloc_inst  = random_inst();
        end
        while (n_alloc < N_INSTR) begin
            drive_cycle(1'b1, ({$random(seed)} % 4) != 0, ({$random(seed)} % 8) != 0);
        end
        while (order_q.size() > 0) drive_cycle(1'b1, 1'b0, 1'b1);
        repeat (3) drive_cycle(1'b0, 1'b0, 1'b1);
        $display("checks %0d, errors %0d", n_checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog/rob_commit.sv */
`timescale 1ns/100ps

module rob_commit (
    input  logic              clk,
    input  logic              rst,
    input  logic              ena,
    rob_head_if.commit        head,
    rob_result_if.commit      res,
    output logic              reg_wr_valid,
    output rob_pkg::reg_idx_t reg_wr_idx,
    output rob_pkg::rob_tag_t reg_wr_tag,
    output rob_pkg::data_t    reg_wr_value,
    output rob_pkg::rob_tag_t store_commit_tag,
    output logic              br_valid,
    output rob_pkg::data_t    br_pc,
    output logic              br_taken,
    output logic              misbranch,
    output rob_pkg::data_t    redirect_pc
);
    import rob_pkg::*;

    commit_kind_e kind;
    logic         retire;
    logic         has_dest;

    always_comb begin
        case (head.head_op)
            OP_BRANCH: kind = ck_branch;
            OP_JALR:   kind = ck_jalr;
            OP_STORE:  kind = ck_store;
            default:   kind = ck_reg;
        endcase
    end

    // oldest entry leaves as soon as its result is in
    assign retire      = ena && head.head_valid && res.ready;
    assign head.retire = retire;
    assign res.retire  = retire;

    assign has_dest = (head.head_dest != reg_idx_t'(0));

    // pulses last one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_wr_valid     <= 1'b0;
            store_commit_tag <= ROB_TAG_NONE;
            br_valid         <= 1'b0;
            misbranch        <= 1'b0;
        end else begin
            reg_wr_valid     <= 1'b0;
            store_commit_tag <= ROB_TAG_NONE;
            br_valid         <= 1'b0;
            misbranch        <= 1'b0;
            if (retire) begin
                case (kind)
                    ck_reg: begin
                        reg_wr_valid <= has_dest;
                    end
                    ck_store: begin
                        store_commit_tag <= head.head_tag;
                    end
                    ck_branch: begin
                        br_valid  <= 1'b1;
                        misbranch <= res.jump_taken != head.head_pred_taken;
                    end
                    ck_jalr: begin
                        // target never predicted, so always redirect
                        br_valid     <= 1'b1;
                        misbranch    <= 1'b1;
                        reg_wr_valid <= has_dest;
                    end
                    default: begin
                        reg_wr_valid <= 1'b0;
                    end
                endcase
            end
        end
    end

    // payload, only meaningful next to its strobe
    always_ff @(posedge clk) begin
        if (retire) begin
            reg_wr_idx   <= head.head_dest;
            reg_wr_tag   <= head.head_tag;
            reg_wr_value <= res.value;
            br_pc        <= head.head_pc;
            br_taken     <= (kind == ck_jalr) || res.jump_taken;
            redirect_pc  <= res.jump_addr;
        end
    end

endmodule

/* verilog/rob_dispatch_queue.sv */
`timescale 1ns/100ps

module rob_dispatch_queue #(
    parameter int ROB_DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             ena,
    input  logic             alloc_valid,
    input  rob_pkg::data_t   alloc_inst,
    input  rob_pkg::reg_idx_t alloc_dest,
    input  rob_pkg::data_t   alloc_pc,
    input  logic             alloc_pred_taken,
    output rob_pkg::rob_tag_t alloc_tag,
    output logic             full,
    rob_head_if.queue        head
);
    import rob_pkg::*;

    rob_tag_t head_ptr;
    rob_tag_t tail_ptr;
    rob_tag_t head_next;
    logic     empty;
    logic     push;
    logic     pop;

    // dispatch fields per entry
    opcode_t  op_arr   [1:ROB_DEPTH];
    reg_idx_t dest_arr [1:ROB_DEPTH];
    data_t    pc_arr   [1:ROB_DEPTH];
    logic     pred_arr [1:ROB_DEPTH];

    // tags run 1..ROB_DEPTH, then wrap back to 1
    function automatic rob_tag_t next_tag(input rob_tag_t tag);
        return (tag == rob_tag_t'(ROB_DEPTH)) ? rob_tag_t'(1) : tag + rob_tag_t'(1);
    endfunction

    if (ROB_DEPTH < 2 || ROB_DEPTH > MAX_ROB_DEPTH) begin : g_depth_check
        $error("rob_dispatch_queue: ROB_DEPTH %0d out of range", ROB_DEPTH);
    end

    assign full      = !empty && (head_ptr == tail_ptr);
    assign alloc_tag = tail_ptr;
    assign push      = ena && alloc_valid && !full;
    assign pop       = ena && head.retire;
    assign head_next = next_tag(head_ptr);

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= rob_tag_t'(1);
            tail_ptr <= rob_tag_t'(1);
            empty    <= 1'b1;
        end else begin
            if (push) begin
                tail_ptr <= next_tag(tail_ptr);
            end
            if (pop) begin
                head_ptr <= head_next;
            end
            // last entry leaving with nothing coming in
            if (push) begin
                empty <= 1'b0;
            end else if (pop && head_next == tail_ptr) begin
                empty <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_arr[tail_ptr]   <= alloc_inst[6:0];
            dest_arr[tail_ptr] <= alloc_dest;
            pc_arr[tail_ptr]   <= alloc_pc;
            pred_arr[tail_ptr] <= alloc_pred_taken;
        end
    end

    assign head.head_valid      = !empty;
    assign head.head_tag        = head_ptr;
    assign head.head_op         = op_arr[head_ptr];
    assign head.head_dest       = dest_arr[head_ptr];
    assign head.head_pc         = pc_arr[head_ptr];
    assign head.head_pred_taken = pred_arr[head_ptr];

    a_retire_needs_entry: assert property (
        @(posedge clk) disable iff (rst) head.retire |-> head.head_valid
    );

endmodule

/* verilog/rob_ifs.sv */
`timescale 1ns/100ps

// head entry of the allocation queue, seen by the commit stage
interface rob_head_if;
    import rob_pkg::*;

    logic     head_valid;
    rob_tag_t head_tag;
    opcode_t  head_op;
    reg_idx_t head_dest;
    data_t    head_pc;
    logic     head_pred_taken;
    logic     retire;

    modport queue (
        output head_valid, head_tag, head_op, head_dest, head_pc, head_pred_taken,
        input  retire
    );

    modport commit (
        input  head_valid, head_tag, head_op, head_dest, head_pc, head_pred_taken,
        output retire
    );
endinterface

// result of the entry at the head tag
interface rob_result_if;
    import rob_pkg::*;

    logic  ready;
    data_t value;
    logic  jump_taken;
    data_t jump_addr;
    logic  retire;

    modport file (
        output ready, value, jump_taken, jump_addr,
        input  retire
    );

    modport commit (
        input  ready, value, jump_taken, jump_addr,
        output retire
    );
endinterface

/* verilog/rob_pkg.sv */
package rob_pkg;

    // datapath word for values, pcs, instructions and addresses
    typedef logic [31:0] data_t;

    // architectural register index, x0 means no write
    typedef logic [4:0] reg_idx_t;

    // rob entry tag, zero is reserved
    typedef logic [3:0] rob_tag_t;

    // instruction bits 6:0
    typedef logic [6:0] opcode_t;

    localparam rob_tag_t ROB_TAG_NONE = 4'd0;

    // largest depth the tag can address without using tag 0
    localparam int MAX_ROB_DEPTH = 15;

    // rv32i opcodes with a special commit action
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_STORE  = 7'b0100011;

    // what the head entry does when it retires
    typedef enum logic [1:0] {
        ck_reg,
        ck_store,
        ck_branch,
        ck_jalr
    } commit_kind_e;

endpackage

/* verilog/rob_result_file.sv */
`timescale 1ns/100ps

module rob_result_file #(
    parameter int ROB_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ena,
    input  logic              alloc_fire,
    input  rob_pkg::rob_tag_t alloc_tag,
    input  rob_pkg::rob_tag_t cdb_tag,
    input  rob_pkg::data_t    cdb_value,
    input  rob_pkg::data_t    cdb_jump_addr,
    input  logic              cdb_is_jump,
    input  rob_pkg::rob_tag_t ls_tag,
    input  rob_pkg::data_t    ls_value,
    input  rob_pkg::rob_tag_t query_tag1,
    input  rob_pkg::rob_tag_t query_tag2,
    output rob_pkg::data_t    query_value1,
    output rob_pkg::data_t    query_value2,
    output logic              query_ready1,
    output logic              query_ready2,
    input  rob_pkg::rob_tag_t head_tag,
    rob_result_if.file        res
);
    import rob_pkg::*;

    logic [ROB_DEPTH:1] ready_arr;
    data_t              value_arr     [1:ROB_DEPTH];
    logic               jump_arr      [1:ROB_DEPTH];
    data_t              jump_addr_arr [1:ROB_DEPTH];

    // tag 0 reads as an empty, never ready slot
    function automatic logic ready_of(input rob_tag_t tag);
        return (tag != ROB_TAG_NONE) && ready_arr[tag];
    endfunction

    function automatic data_t value_of(input rob_tag_t tag);
        return (tag == ROB_TAG_NONE) ? data_t'(0) : value_arr[tag];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_arr <= '0;
        end else if (ena) begin
            // clears first, so a write-back in the same cycle lands
            if (res.retire) begin
                ready_arr[head_tag] <= 1'b0;
            end
            if (alloc_fire) begin
                ready_arr[alloc_tag] <= 1'b0;
            end
            if (cdb_tag != ROB_TAG_NONE) begin
                ready_arr[cdb_tag] <= 1'b1;
            end
            if (ls_tag != ROB_TAG_NONE) begin
                ready_arr[ls_tag] <= 1'b1;
            end
        end
    end

    // load/store value written last wins on a shared tag
    always_ff @(posedge clk) begin
        if (ena) begin
            if (cdb_tag != ROB_TAG_NONE) begin
                value_arr[cdb_tag]     <= cdb_value;
                jump_arr[cdb_tag]      <= cdb_is_jump;
                jump_addr_arr[cdb_tag] <= cdb_jump_addr;
            end
            if (ls_tag != ROB_TAG_NONE) begin
                value_arr[ls_tag] <= ls_value;
            end
        end
    end

    always_comb begin
        query_ready1 = ready_of(query_tag1);
        query_value1 = value_of(query_tag1);
        query_ready2 = ready_of(query_tag2);
        query_value2 = value_of(query_tag2);
        res.ready      = ready_of(head_tag);
        res.value      = value_of(head_tag);
        res.jump_taken = jump_arr[head_tag];
        res.jump_addr  = jump_addr_arr[head_tag];
    end

    // memory unit must not answer twice for one entry
    a_ls_not_ready: assert property (
        @(posedge clk) disable iff (rst)
        (ena && ls_tag != ROB_TAG_NONE) |-> !ready_arr[ls_tag]
    );

endmodule

/* verilog/rob_top.sv */
`timescale 1ns/100ps

module rob_top #(
    parameter int ROB_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ena,
    // allocation from decode
    input  logic              alloc_valid,
    input  rob_pkg::data_t    alloc_inst,
    input  rob_pkg::reg_idx_t alloc_dest,
    input  rob_pkg::data_t    alloc_pc,
    input  logic              alloc_pred_taken,
    output rob_pkg::rob_tag_t alloc_tag,
    output logic              full,
    // write-back buses
    input  rob_pkg::rob_tag_t cdb_tag,
    input  rob_pkg::data_t    cdb_value,
    input  rob_pkg::data_t    cdb_jump_addr,
    input  logic              cdb_is_jump,
    input  rob_pkg::rob_tag_t ls_tag,
    input  rob_pkg::data_t    ls_value,
    // operand lookup
    input  rob_pkg::rob_tag_t query_tag1,
    input  rob_pkg::rob_tag_t query_tag2,
    output rob_pkg::data_t    query_value1,
    output rob_pkg::data_t    query_value2,
    output logic              query_ready1,
    output logic              query_ready2,
    // commit side
    output logic              reg_wr_valid,
    output rob_pkg::reg_idx_t reg_wr_idx,
    output rob_pkg::rob_tag_t reg_wr_tag,
    output rob_pkg::data_t    reg_wr_value,
    output rob_pkg::rob_tag_t store_commit_tag,
    output logic              br_valid,
    output rob_pkg::data_t    br_pc,
    output logic              br_taken,
    output logic              misbranch,
    output rob_pkg::data_t    redirect_pc
);

    logic alloc_fire;

    rob_head_if   head_bus ();
    rob_result_if res_bus ();

    assign alloc_fire = ena && alloc_valid && !full;

    rob_dispatch_queue #(.ROB_DEPTH(ROB_DEPTH)) u_queue (
        .clk, .rst, .ena,
        .alloc_valid, .alloc_inst, .alloc_dest, .alloc_pc, .alloc_pred_taken,
        .alloc_tag, .full,
        .head (head_bus.queue)
    );

    rob_result_file #(.ROB_DEPTH(ROB_DEPTH)) u_results (
        .clk, .rst, .ena,
        .alloc_fire, .alloc_tag,
        .cdb_tag, .cdb_value, .cdb_jump_addr, .cdb_is_jump,
        .ls_tag, .ls_value,
        .query_tag1, .query_tag2, .query_value1, .query_value2,
        .query_ready1, .query_ready2,
        .head_tag (head_bus.head_tag),
        .res      (res_bus.file)
    );

    rob_commit u_commit (
        .clk, .rst, .ena,
        .head (head_bus.commit),
        .res  (res_bus.commit),
        .reg_wr_valid, .reg_wr_idx, .reg_wr_tag, .reg_wr_value,
        .store_commit_tag,
        .br_valid, .br_pc, .br_taken, .misbranch, .redirect_pc
    );

endmodule
